// ==== sources.f ====
+incdir+include
hdl/lockInPkg.sv
hdl/lockInControl.sv
hdl/modulationIntegrator.sv
hdl/demodChannel.sv
hdl/lockInTop.sv
tests/lockInTb.sv

// ==== include/lockInVectors.svh ====
`ifndef LOCK_IN_VECTORS_SVH
`define LOCK_IN_VECTORS_SVH

// How sIn is driven during a row
typedef enum logic {
    modeConst,
    modeRandom  // New value after each slow tick
} inModeT;

// What each latched demod output is compared against
typedef enum logic {
    expectZero,
    expectModel
} expectT;

typedef struct packed {
    logic [7:0]        periods;    // Modulation periods of 60 slow ticks
    inModeT            inMode;
    lockInPkg::sampleT constVal;   // Used in modeConst only
    expectT            expectKind;
} vectorT;

localparam int numVectors = 6;

localparam vectorT vectorTable [numVectors] = '{
    '{periods: 8'd2, inMode: modeConst,  constVal: 16'sd100,   expectKind: expectZero},
    '{periods: 8'd2, inMode: modeConst,  constVal: -16'sd2500, expectKind: expectZero},
    '{periods: 8'd3, inMode: modeRandom, constVal: 16'sd0,     expectKind: expectModel},
    '{periods: 8'd1, inMode: modeConst,  constVal: 16'sd0,     expectKind: expectZero},
    '{periods: 8'd3, inMode: modeRandom, constVal: 16'sd0,     expectKind: expectModel},
    '{periods: 8'd2, inMode: modeConst,  constVal: 16'sd32767, expectKind: expectZero}
};

`endif

// ==== tests/lockInTb.sv ====
`timescale 1ns/100ps

module lockInTb;
    import lockInPkg::*;

    `include "lockInVectors.svh"

    localparam int demodWidth = 16;
    localparam int fastDiv    = 2;
    localparam int slowDiv    = 3;
    localparam int slowPeriod = fastDiv * slowDiv; // Clocks per slow tick
    localparam int modPeriod  = 60;                // Slow ticks per modulation period
    localparam int topLevel   = 12;
    localparam int numChans   = 6;

    typedef logic signed [demodWidth-1:0] demodT;

    // Channel order f, fQ, 2f, 2fQ, 3f, 3fQ
    localparam int zeroLens   [numChans] = '{10, 10, 4, 4, 2, 2};
    localparam int activeLens [numChans] = '{20, 20, 11, 11, 8, 8};
    localparam bit quadFlags  [numChans] = '{1'b0, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1};
    string chanNames [numChans] = '{"demodF", "demodFQ", "demod2f", "demod2fQ",
                                    "demod3f", "demod3fQ"};

    logic     clk;
    logic     rstN;
    divT      divFast;
    divT      divSlow;
    sampleT   sIn;
    modSlopeT modSlope;
    modIntT   modOut;
    demodT    demodF, demodFQ, demod2f, demod2fQ, demod3f, demod3fQ;

    int     phase     [numChans]; // Position inside the window period
    demodT  modelSum  [numChans];
    demodT  expected  [numChans];
    logic   pending   [numChans]; // Latch happened, check on the next clock
    logic   zeroDue   [numChans];
    logic   clean     [numChans]; // Full window of one constant value
    logic   haveFirst [numChans];
    sampleT firstVal  [numChans];
    int     expSlope  [modPeriod];
    int     slowCount;
    int     stepClocks;
    int     cycleCount;
    int     timeoutLimit;
    integer seed;
    modIntT modExpected; // Integrator output one clock after each slow tick

    lockInTop #(.demodWidth(demodWidth)) lockInTop_i (
        .clk(clk), .rstN(rstN), .divFast(divFast), .divSlow(divSlow), .sIn(sIn),
        .modSlope(modSlope), .modOut(modOut), .demodF(demodF), .demodFQ(demodFQ),
        .demod2f(demod2f), .demod2fQ(demod2fQ), .demod3f(demod3f), .demod3fQ(demod3fQ)
    );

    always #50 clk = ~clk;

    ////////////////////////////////
    // Helpers
    ////////////////////////////////

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expVal);
        if (actual !== expVal) begin
            abortRun($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, actual, expVal));
        end
    endtask

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > timeoutLimit) begin
            abortRun($sformatf("Timeout: run did not finish in %0d cycles", timeoutLimit));
        end
    end

    function automatic int totalPeriods();
        int sum;
        sum = 0;
        for (int r = 0; r < numVectors; r++) sum += vectorTable[r].periods;
        return sum;
    endfunction

    function automatic demodT demodValue(input int ch);
        case (ch)
            0:       return demodF;
            1:       return demodFQ;
            2:       return demod2f;
            3:       return demod2fQ;
            4:       return demod3f;
            default: return demod3fQ;
        endcase
    endfunction

    // Window gain at a phase, zeroA positive zeroMid negative zeroB
    function automatic int gainAt(input int ch, input int ph);
        int posStart;
        int negStart;
        posStart = zeroLens[ch] / 2;
        negStart = posStart + activeLens[ch] + zeroLens[ch];
        if (ph >= posStart && ph < posStart + activeLens[ch]) return 1;
        if (ph >= negStart && ph < negStart + activeLens[ch]) return -1;
        return 0;
    endfunction

    // Slope per step of one period, topHoldA count 0 first
    task automatic buildSlopes();
        int segLens [9];
        int deltas  [9];
        int level;
        int idx;
        segLens = '{4, 10, 2, 10, 8, 10, 2, 10, 4};
        deltas  = '{0, -1, -2, -1, 0, 1, 2, 1, 0};
        level = topLevel;
        idx = 0;
        for (int seg = 0; seg < 9; seg++) begin
            for (int n = 0; n < segLens[seg]; n++) begin
                level = (seg == 0) ? topLevel : level + deltas[seg];
                expSlope[idx] = level;
                idx++;
            end
        end
    endtask

    ////////////////////////////////
    // Reference model
    ////////////////////////////////

    task automatic resetModel();
        for (int ch = 0; ch < numChans; ch++) begin
            phase[ch]     = quadFlags[ch] ? zeroLens[ch] / 2 + activeLens[ch] / 2 - 1 : 0;
            modelSum[ch]  = '0;
            pending[ch]   = 1'b0;
            zeroDue[ch]   = 1'b0;
            clean[ch]     = !quadFlags[ch]; // Quadrature starts mid window
            haveFirst[ch] = 1'b0;
        end
    endtask

    task automatic modelStep(input int r);
        int g;
        for (int ch = 0; ch < numChans; ch++) begin
            phase[ch] = (phase[ch] + 1) % (2 * (zeroLens[ch] + activeLens[ch]));
            g = gainAt(ch, phase[ch]);
            if (g != 0) begin
                if (!haveFirst[ch]) begin
                    firstVal[ch]  = sIn;
                    haveFirst[ch] = 1'b1;
                end else if (sIn != firstVal[ch]) begin
                    clean[ch] = 1'b0;
                end
                modelSum[ch] = (g > 0) ? modelSum[ch] + demodT'(sIn)
                                       : modelSum[ch] - demodT'(sIn);
            end
            if (phase[ch] == 2 * (zeroLens[ch] + activeLens[ch]) - 1) begin // Latch
                expected[ch]  = modelSum[ch];
                pending[ch]   = 1'b1;
                zeroDue[ch]   = clean[ch] && (vectorTable[r].expectKind == expectZero);
                modelSum[ch]  = '0;
                clean[ch]     = 1'b1;
                haveFirst[ch] = 1'b0;
            end
        end
    endtask

    ////////////////////////////////
    // Checks
    ////////////////////////////////

    task automatic checkReset();
        checkValue("modSlope", 32'(modSlope), 32'h0);
        checkValue("modOut", 32'(modOut), 32'h0);
        for (int ch = 0; ch < numChans; ch++) begin
            checkValue(chanNames[ch], 32'(demodValue(ch)), 32'h0);
        end
    endtask

    // One clock after a slow tick
    task automatic checkAfterStep();
        int idx;
        idx = slowCount % modPeriod;
        if (slowCount > 0) begin
            checkValue("modSlope", 32'(modSlope), 32'(expSlope[idx]));
            if (idx == 0) begin
                modExpected = modIntT'(6 * slowDiv); // Reload
            end else if (slowCount > 1) begin        // Slope is zero before the first step
                // divSlow fast ticks per step, each adds the previous step's slope
                modExpected = modExpected + modIntT'(slowDiv * expSlope[idx - 1]);
            end
            checkValue("modOut", 32'(modOut), 32'(modExpected));
        end
        for (int ch = 0; ch < numChans; ch++) begin
            if (pending[ch]) begin
                checkValue(chanNames[ch], 32'(demodValue(ch)), 32'(expected[ch]));
                if (zeroDue[ch]) checkValue(chanNames[ch], 32'(demodValue(ch)), 32'h0);
                pending[ch] = 1'b0;
            end
        end
    endtask

    task automatic driveInput(input int r);
        if (vectorTable[r].inMode == modeRandom) sIn = sampleT'($random(seed));
        else sIn = vectorTable[r].constVal;
    endtask

    ////////////////////////////////
    // Main sequence
    ////////////////////////////////

    initial begin
        clk          = 1'b0;
        rstN         = 1'b0;
        divFast      = divT'(fastDiv);
        divSlow      = divT'(slowDiv);
        sIn          = '0;
        seed         = 32'h7a64;
        slowCount    = 0;
        cycleCount   = 0;
        modExpected  = '0;
        timeoutLimit = totalPeriods() * modPeriod * slowPeriod + 100;
        buildSlopes();
        resetModel();
        repeat (4) @(negedge clk);
        rstN = 1'b1;
        @(negedge clk);
        checkReset();
        for (int r = 0; r < numVectors; r++) begin
            for (int s = 0; s < vectorTable[r].periods * modPeriod; s++) begin
                @(negedge clk);
                checkAfterStep();
                driveInput(r);   // Held until the next slow tick is taken
                stepClocks = 1;
                while (!lockInTop_i.ticks.slowTick) begin
                    @(negedge clk);
                    stepClocks++;
                end
                if (slowCount > 0) checkValue("slowTick spacing", 32'(stepClocks), 32'(slowPeriod));
                slowCount++;
                modelStep(r);
            end
        end
        @(negedge clk);
        checkAfterStep();
        $display("TEST PASS");
        $finish;
    end

endmodule

// ==== hdl/lockInTop.sv ====
`timescale 1ns/100ps

module lockInTop #(
    parameter int demodWidth = 16
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  lockInPkg::divT               divFast,
    input  lockInPkg::divT               divSlow,
    input  lockInPkg::sampleT            sIn,
    output lockInPkg::modSlopeT          modSlope,
    output lockInPkg::modIntT            modOut,
    output logic signed [demodWidth-1:0] demodF,
    output logic signed [demodWidth-1:0] demodFQ,
    output logic signed [demodWidth-1:0] demod2f,
    output logic signed [demodWidth-1:0] demod2fQ,
    output logic signed [demodWidth-1:0] demod3f,
    output logic signed [demodWidth-1:0] demod3fQ
);
    import lockInPkg::*;

    // Window lengths in slow ticks, period is 2 * (zero + active)
    localparam int fZeroLen    = 10;
    localparam int fActiveLen  = 20;
    localparam int f2ZeroLen   = 4;
    localparam int f2ActiveLen = 11;
    localparam int f3ZeroLen   = 2;
    localparam int f3ActiveLen = 8;

    tickT  ticks;
    shapeT shape;

    //////////////////////////////
    // Modulation
    //////////////////////////////

    lockInControl lockInControl_i (
        .clk     (clk),
        .rstN    (rstN),
        .divFast (divFast),
        .divSlow (divSlow),
        .ticks   (ticks),
        .shape   (shape)
    );

    modulationIntegrator modulationIntegrator_i (
        .clk     (clk),
        .rstN    (rstN),
        .divSlow (divSlow),
        .ticks   (ticks),
        .shape   (shape),
        .modOut  (modOut)
    );

    assign modSlope = shape.slope;

    //////////////////////////////
    // Demodulation at f, 2f, 3f
    //////////////////////////////

    demodChannel #(.demodWidth(demodWidth), .zeroLen(fZeroLen),
                   .activeLen(fActiveLen), .quadrature(1'b0)) demodF_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demodF)
    );

    demodChannel #(.demodWidth(demodWidth), .zeroLen(fZeroLen),
                   .activeLen(fActiveLen), .quadrature(1'b1)) demodFQ_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demodFQ)
    );

    demodChannel #(.demodWidth(demodWidth), .zeroLen(f2ZeroLen),
                   .activeLen(f2ActiveLen), .quadrature(1'b0)) demod2f_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demod2f)
    );

    demodChannel #(.demodWidth(demodWidth), .zeroLen(f2ZeroLen),
                   .activeLen(f2ActiveLen), .quadrature(1'b1)) demod2fQ_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demod2fQ)
    );

    demodChannel #(.demodWidth(demodWidth), .zeroLen(f3ZeroLen),
                   .activeLen(f3ActiveLen), .quadrature(1'b0)) demod3f_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demod3f)
    );

    demodChannel #(.demodWidth(demodWidth), .zeroLen(f3ZeroLen),
                   .activeLen(f3ActiveLen), .quadrature(1'b1)) demod3fQ_i (
        .clk(clk), .rstN(rstN), .ticks(ticks), .sIn(sIn), .demodOut(demod3fQ)
    );

endmodule

// ==== hdl/demodChannel.sv ====
`timescale 1ns/100ps

module demodChannel #(
    parameter int demodWidth = 16,
    parameter int zeroLen    = 10,
    parameter int activeLen  = 20,
    parameter bit quadrature = 1'b0
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  lockInPkg::tickT              ticks,
    input  lockInPkg::sampleT            sIn,
    output logic signed [demodWidth-1:0] demodOut
);
    import lockInPkg::*;

    typedef logic signed [demodWidth-1:0] sumT;

    // Quadrature window is shifted by a quarter period
    localparam windowStateT startState = quadrature ? positive : zeroA;
    localparam segCountT    startCount =
        quadrature ? segCountT'(activeLen / 2 - 1) : segCountT'(0);

    windowStateT winState;
    windowStateT nextState;
    segCountT    winCount;
    segCountT    nextCount;
    logic        lastStep;
    sumT         accSum;

    //////////////////////////////
    // Window FSM
    //////////////////////////////

    function automatic segCountT winLen(input windowStateT s);
        case (s)
            positive, negative: winLen = segCountT'(activeLen);
            zeroMid:            winLen = segCountT'(zeroLen);
            default:            winLen = segCountT'(zeroLen / 2); // Outer zeros
        endcase
    endfunction

    always_comb begin
        if (winCount == winLen(winState) - segCountT'(1)) begin
            nextCount = '0;
            case (winState)
                zeroA:    nextState = positive;
                positive: nextState = zeroMid;
                zeroMid:  nextState = negative;
                negative: nextState = zeroB;
                default:  nextState = zeroA;
            endcase
        end else begin
            nextCount = winCount + segCountT'(1);
            nextState = winState;
        end
    end

    // Entering the final count of zeroB closes the window
    assign lastStep = (nextState == zeroB) &&
                      (nextCount == segCountT'(zeroLen / 2 - 1));

    //////////////////////////////
    // Accumulate and latch
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            winState <= startState;
            winCount <= startCount;
            accSum   <= '0;
            demodOut <= '0;
        end else if (ticks.slowTick) begin
            winState <= nextState;
            winCount <= nextCount;
            case (nextState)
                positive: accSum <= accSum + sumT'(sIn);
                negative: accSum <= accSum - sumT'(sIn);
                zeroB: begin
                    if (lastStep) begin
                        demodOut <= accSum;
                        accSum   <= '0;
                    end
                end
                default: begin
                    accSum <= accSum; // No gain
                end
            endcase
        end
    end

    // Window steps follow the slow tick from the control block
    winOnSlowTick: assert property (
        @(posedge clk) disable iff (!rstN)
        !$stable(winState) |-> $past(ticks.slowTick)
    ) else $error("window state changed without slowTick");

endmodule

// ==== hdl/modulationIntegrator.sv ====
`timescale 1ns/100ps

module modulationIntegrator (
    input  logic              clk,
    input  logic              rstN,
    input  lockInPkg::divT    divSlow,
    input  lockInPkg::tickT   ticks,
    input  lockInPkg::shapeT  shape,
    output lockInPkg::modIntT modOut
);
    import lockInPkg::*;

    modIntT divSlowExt;
    modIntT offset;
    modIntT slopeExt;

    //////////////////////////////
    // Offset and slope extension
    //////////////////////////////

    assign divSlowExt = modIntT'({10'd0, divSlow});

    // 6 * divSlow gives a waveform with zero mean
    assign offset = (divSlowExt <<< 2) + (divSlowExt <<< 1);

    assign slopeExt = modIntT'(shape.slope); // Sign extended

    //////////////////////////////
    // Integrator
    //////////////////////////////

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            modOut <= '0;
        end else if (ticks.fastTick) begin
            if (shape.periodStart) begin
                modOut <= offset;            // Period boundary reload
            end else begin
                modOut <= modOut + slopeExt;
            end
        end
    end

    // Bounded only while the sequencer produces a balanced profile
    modInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        (modOut < (2 ** 24)) && (modOut > -(2 ** 24))
    ) else $error("modOut out of range: %0d", modOut);

endmodule

// ==== hdl/lockInControl.sv ====
`timescale 1ns/100ps

module lockInControl (
    input  logic             clk,
    input  logic             rstN,
    input  lockInPkg::divT   divFast,
    input  lockInPkg::divT   divSlow,
    output lockInPkg::tickT  ticks,
    output lockInPkg::shapeT shape
);
    import lockInPkg::*;

    // Top hold level, reached again after all ramps
    localparam modSlopeT topSlope = modSlopeT'(slowRampLen + fastRampLen);

    divT        fastCount;
    divT        slowCount;
    logic       fastWrap;
    logic       slowWrap;

    shapeStateT shapeState;
    shapeStateT nextState;
    segCountT   segCount;
    segCountT   nextCount;
    modSlopeT   slopeDelta;
    logic       nextPeriodStart;

    //////////////////////////////
    // Tick divider
    //////////////////////////////

    assign fastWrap = (fastCount == divFast - divT'(1));
    assign slowWrap = (slowCount == divSlow - divT'(1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            fastCount <= '0;
            slowCount <= '0;
            ticks     <= '0;
        end else begin
            ticks.fastTick <= fastWrap;
            ticks.slowTick <= fastWrap && slowWrap; // Every divSlow-th fast tick
            if (fastWrap) begin
                fastCount <= '0;
                slowCount <= slowWrap ? divT'(0) : slowCount + divT'(1);
            end else begin
                fastCount <= fastCount + divT'(1);
            end
        end
    end

    //////////////////////////////
    // Shape sequencer
    //////////////////////////////

    function automatic segCountT segLen(input shapeStateT s);
        case (s)
            topHoldA, topHoldB:     segLen = segCountT'(holdLen / 2);
            downA, downC, upA, upC: segLen = segCountT'(slowRampLen);
            downB, upB:             segLen = segCountT'(fastRampLen);
            default:                segLen = segCountT'(holdLen); // bottomHold
        endcase
    endfunction

    always_comb begin
        if (segCount == segLen(shapeState) - segCountT'(1)) begin
            nextCount = '0;
            if (shapeState == topHoldB) begin
                nextState = topHoldA;
            end else begin
                nextState = shapeStateT'(shapeState + 4'd1);
            end
        end else begin
            nextCount = segCount + segCountT'(1);
            nextState = shapeState;
        end
    end

    // Slope change applied on entering each step of a segment
    always_comb begin
        case (nextState)
            downA, downC: slopeDelta = modSlopeT'(-slopeStep);
            downB:        slopeDelta = modSlopeT'(-2 * slopeStep); // Steep part of the ramp
            upA, upC:     slopeDelta = modSlopeT'(slopeStep);
            upB:          slopeDelta = modSlopeT'(2 * slopeStep);
            default:      slopeDelta = '0;                         // Holds
        endcase
    end

    assign nextPeriodStart = (nextState == topHoldB) &&
                             (nextCount == segCountT'(holdLen / 2 - 1));

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            shapeState <= topHoldA;
            segCount   <= '0;
            shape      <= '0;
        end else if (ticks.slowTick) begin
            shapeState        <= nextState;
            segCount          <= nextCount;
            shape.periodStart <= nextPeriodStart;
            if (nextState == topHoldA) begin
                shape.slope <= topSlope; // Reload keeps the level exact
            end else begin
                shape.slope <= shape.slope + slopeDelta;
            end
        end
    end

    // Both ticks come from one counter chain
    slowNeedsFast: assert property (
        @(posedge clk) disable iff (!rstN)
        ticks.slowTick |-> ticks.fastTick
    ) else $error("slowTick without fastTick");

endmodule

// ==== hdl/lockInPkg.sv ====
package lockInPkg;

    //////////////////////////////
    // Data types
    //////////////////////////////

    typedef logic signed [15:0] sampleT;   // Signed input sample
    typedef logic        [15:0] divT;      // Divider setting and counter
    typedef logic        [7:0]  segCountT; // Count within one segment
    typedef logic signed [5:0]  modSlopeT; // Slope level, -12 to +12
    typedef logic signed [25:0] modIntT;   // Integrated modulation

    // Segments of the slope profile, one full modulation period
    typedef enum logic [3:0] {
        topHoldA,
        downA,
        downB,
        downC,
        bottomHold,
        upA,
        upB,
        upC,
        topHoldB
    } shapeStateT;

    // Segments of the demodulation window
    typedef enum logic [2:0] {
        zeroA,
        positive,
        zeroMid,
        negative,
        zeroB
    } windowStateT;

    typedef struct packed {
        logic fastTick;
        logic slowTick;   // Always coincides with a fastTick
    } tickT;

    typedef struct packed {
        modSlopeT slope;
        logic     periodStart; // Last step of topHoldB
    } shapeT;

    //////////////////////////////
    // Segment lengths in slow ticks
    //////////////////////////////

    localparam int holdLen     = 8;  // Split over topHoldA and topHoldB
    localparam int slowRampLen = 10;
    localparam int fastRampLen = 2;
    localparam int slopeStep   = 1;  // Slope change per step on slow ramps

endpackage
